/* pipe_ctrl_pkg.sv */
//------------------------------
// Shared types and constants for the pipeline control logic
// Opcode values follow the RV32I base encoding
//------------------------------
`default_nettype none

package pipe_ctrl_pkg;

    // Architectural register index
    // Index 0 names x0, which reads as zero and never carries a hazard
    typedef logic [4:0] reg_idx_t;

    // Major opcode field, instruction bits [6:0]
    typedef logic [6:0] opcode_t;

    // Unconditional jumps that redirect fetch once they reach EX
    localparam opcode_t OPC_JAL   = 7'b1101111;
    localparam opcode_t OPC_JALR  = 7'b1100111;

    // Load and store major opcodes
    // The decoder resolves these into flags before they reach this logic
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Source of an EX operand
    // Code 2'd3 is reserved and never driven
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    // Hazard configuration word
    // Bit 0 enables operand forwarding
    // Bit 1 marks a register file that writes through to a same-cycle read
    typedef logic [1:0] hz_cfg_t;

    // Forwarding on and no write-through out of reset
    localparam hz_cfg_t HZ_CFG_RESET = 2'b01;

endpackage

`default_nettype wire

/* hazard_cfg_regs.sv */
//------------------------------
// Two-bit hazard configuration register
// A write lands on the edge after cfg_we and steers the next cycle
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module hazard_cfg_regs
    import pipe_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    cfg_we,
    input  wire hz_cfg_t cfg_wdata,
    output hz_cfg_t      cfg_rdata,
    output logic         fwd_en,
    output logic         rf_bypass
);

    hz_cfg_t cfg_q;

    // Configuration word, loaded by a one-cycle strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q <= HZ_CFG_RESET;
        end else if (cfg_we) begin
            cfg_q <= cfg_wdata;
        end
    end

    // Readback shows the live register and not the pending write
    assign cfg_rdata = cfg_q;

    // Steering levels for the hazard and forwarding logic
    assign fwd_en    = cfg_q[0];
    assign rf_bypass = cfg_q[1];

    //------------------------------
    // Checks
    //------------------------------
    // A written word must be visible on the readback one cycle later
    a_cfg_readback : assert property (
        @(posedge clk) disable iff (!arst_n)
        cfg_we |=> (cfg_rdata == $past(cfg_wdata))
    ) else $error("hazard_cfg_regs: readback differs from last written word");

endmodule

`default_nettype wire

/* stage_tracker.sv */
//------------------------------
// Control-field shadow of the ID/EX, EX/MEM and MEM/WB registers
// Only ID/EX can hold a bubble and nothing below EX ever stalls
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module stage_tracker
    import pipe_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     idex_flush,
    // Fields of the instruction in ID
    input  wire logic     d_valid,
    input  wire reg_idx_t d_rs1,
    input  wire reg_idx_t d_rs2,
    input  wire reg_idx_t d_rd,
    input  wire logic     d_regwren,
    input  wire logic     d_memren,
    input  wire logic     d_memwren,
    input  wire opcode_t  d_opcode,
    // EX stage
    output logic          e_valid,
    output reg_idx_t      e_rs1,
    output reg_idx_t      e_rs2,
    output reg_idx_t      e_rd,
    output logic          e_regwren,
    output logic          e_memren,
    output opcode_t       e_opcode,
    // MEM stage
    output logic          m_valid,
    output reg_idx_t      m_rd,
    output reg_idx_t      m_rs2,
    output logic          m_regwren,
    output logic          m_memwren,
    // WB stage
    output logic          w_valid,
    output reg_idx_t      w_rd,
    output logic          w_regwren
);

    // Store flag of the EX instruction, only needed to feed MEM
    logic e_memwren;

    //------------------------------
    // Control state
    //------------------------------
    // Flags are qualified with valid so a bubble is never seen as a writer
    // A register write to x0 is dropped here as well
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid   <= 1'b0;
            e_regwren <= 1'b0;
            e_memren  <= 1'b0;
            e_memwren <= 1'b0;
            m_valid   <= 1'b0;
            m_regwren <= 1'b0;
            m_memwren <= 1'b0;
            w_valid   <= 1'b0;
            w_regwren <= 1'b0;
        end else begin
            if (idex_flush) begin
                // Bubble into EX while ID holds or is squashed
                e_valid   <= 1'b0;
                e_regwren <= 1'b0;
                e_memren  <= 1'b0;
                e_memwren <= 1'b0;
            end else begin
                e_valid   <= d_valid;
                e_regwren <= d_valid & d_regwren & (d_rd != '0);
                e_memren  <= d_valid & d_memren;
                e_memwren <= d_valid & d_memwren;
            end
            // Lower stages always advance
            m_valid   <= e_valid;
            m_regwren <= e_regwren;
            m_memwren <= e_memwren;
            w_valid   <= m_valid;
            w_regwren <= m_regwren;
        end
    end

    //------------------------------
    // Payload fields
    //------------------------------
    // These are only looked at together with a qualified flag
    always_ff @(posedge clk) begin
        e_rs1    <= d_rs1;
        e_rs2    <= d_rs2;
        e_rd     <= d_rd;
        e_opcode <= d_opcode;
        m_rd     <= e_rd;
        m_rs2    <= e_rs2;
        w_rd     <= m_rd;
    end

    //------------------------------
    // Checks
    //------------------------------
    // A decoded instruction is never both a load and a store
    a_ld_st_excl : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(e_memren && e_memwren)
    ) else $error("stage_tracker: EX marked as load and store");

    // A flushed slot must reach EX, then MEM, then WB with no write flags
    a_bubble_clean : assert property (
        @(posedge clk) disable iff (!arst_n)
        idex_flush |=> (!e_valid && !e_regwren && !e_memren && !e_memwren)
                   ##1 (!m_valid && !m_regwren && !m_memwren)
                   ##1 (!w_valid && !w_regwren)
    ) else $error("stage_tracker: bubble carried a write flag");

endmodule

`default_nettype wire

/* hazard_detect.sv */
//------------------------------
// Stall and flush decisions for IF/ID and ID/EX
// d_rs1 and d_rs2 are compared even for an invalid ID slot
// e_br_taken is trusted to be low for a bubble in EX
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module hazard_detect
    import pipe_ctrl_pkg::*;
(
    input  wire reg_idx_t       d_rs1,
    input  wire reg_idx_t       d_rs2,
    input  wire logic           e_valid,
    input  wire reg_idx_t       e_rd,
    input  wire logic           e_regwren,
    input  wire logic           e_memren,
    input  wire opcode_t        e_opcode,
    input  wire reg_idx_t       m_rd,
    input  wire logic           m_regwren,
    input  wire reg_idx_t       w_rd,
    input  wire logic           w_regwren,
    input  wire logic           e_br_taken,
    input  wire logic           fwd_en,
    input  wire logic           rf_bypass,
    output logic                stall_if,
    output logic                ifid_wren,
    output logic                ifid_flush,
    output logic                idex_flush
);

    logic e_match;
    logic m_match;
    logic w_match;
    logic load_use;
    logic wb_dec;
    logic no_fwd;
    logic cf_change;
    logic stall_raw;

    //------------------------------
    // Source matches per stage
    //------------------------------
    // A stage matches when it targets a nonzero rd read by the ID instruction
    assign e_match = (e_rd != '0) && ((e_rd == d_rs1) || (e_rd == d_rs2));
    assign m_match = (m_rd != '0) && ((m_rd == d_rs1) || (m_rd == d_rs2));
    assign w_match = (w_rd != '0) && ((w_rd == d_rs1) || (w_rd == d_rs2));

    // Load data is not ready before MEM so the consumer waits one cycle
    assign load_use = e_memren & e_match;

    // Without write-through the WB write lands after the ID read
    assign wb_dec = w_regwren & w_match & ~rf_bypass;

    // With forwarding off every writer still in flight must drain first
    assign no_fwd = ~fwd_en & ((e_regwren & e_match) | (m_regwren & m_match));

    assign stall_raw = load_use | wb_dec | no_fwd;

    // Redirect from EX, either a resolved branch or a jump
    assign cf_change = e_br_taken |
                       (e_valid & ((e_opcode == OPC_JAL) || (e_opcode == OPC_JALR)));

    //------------------------------
    // Pipeline control
    //------------------------------
    // A redirect wins since the stalled ID instruction is on the wrong path
    assign stall_if   = stall_raw & ~cf_change;
    assign ifid_wren  = ~stall_if;
    assign ifid_flush = cf_change;
    assign idex_flush = stall_if | cf_change;

    // Holding IF/ID while also squashing it would lose the redirect
    always_comb begin
        assert (!(stall_if && ifid_flush))
            else $error("hazard_detect: stall and IF/ID flush together");
    end

endmodule

`default_nettype wire

/* forward_select.sv */
//------------------------------
// Operand forwarding selects for EX and the WB-to-MEM store data path
// MEM is the younger producer and wins over WB
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module forward_select
    import pipe_ctrl_pkg::*;
(
    input  wire logic     e_valid,
    input  wire reg_idx_t e_rs1,
    input  wire reg_idx_t e_rs2,
    input  wire reg_idx_t m_rd,
    input  wire reg_idx_t m_rs2,
    input  wire logic     m_regwren,
    input  wire logic     m_memwren,
    input  wire reg_idx_t w_rd,
    input  wire logic     w_regwren,
    input  wire logic     fwd_en,
    output fwd_sel_t      rs1_sel,
    output fwd_sel_t      rs2_sel,
    output logic          wm_fwd_sel
);

    logic fwd_ok;
    logic m_live;
    logic w_live;

    // Selects stay at FWD_NONE for a bubble or with forwarding disabled
    assign fwd_ok = fwd_en & e_valid;

    // A producer counts only when it writes a nonzero register
    assign m_live = m_regwren & (m_rd != '0);
    assign w_live = w_regwren & (w_rd != '0);

    //------------------------------
    // EX operand selects
    //------------------------------
    always_comb begin
        rs1_sel = FWD_NONE;
        rs2_sel = FWD_NONE;
        if (fwd_ok) begin
            if (m_live && (m_rd == e_rs1)) begin
                rs1_sel = FWD_MEM;
            end else if (w_live && (w_rd == e_rs1)) begin
                rs1_sel = FWD_WB;
            end
            if (m_live && (m_rd == e_rs2)) begin
                rs2_sel = FWD_MEM;
            end else if (w_live && (w_rd == e_rs2)) begin
                rs2_sel = FWD_WB;
            end
        end
    end

    // Store in MEM picks up its data from the instruction retiring in WB
    assign wm_fwd_sel = fwd_en & m_memwren & w_live & (w_rd == m_rs2);

    // The reserved select code would steer the operand mux to nothing
    always_comb begin
        assert ((rs1_sel != fwd_sel_t'(2'd3)) && (rs2_sel != fwd_sel_t'(2'd3)))
            else $error("forward_select: reserved select code driven");
    end

endmodule

`default_nettype wire

/* pipe_ctrl_top.sv */
//------------------------------
// Pipeline control for a five-stage RV32I core
// ID fields must stay steady while stall_if is high
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     d_valid,
    input  wire reg_idx_t d_rs1,
    input  wire reg_idx_t d_rs2,
    input  wire reg_idx_t d_rd,
    input  wire logic     d_regwren,
    input  wire logic     d_memren,
    input  wire logic     d_memwren,
    input  wire opcode_t  d_opcode,
    input  wire logic     e_br_taken,
    input  wire logic     cfg_we,
    input  wire hz_cfg_t  cfg_wdata,
    output hz_cfg_t       cfg_rdata,
    output logic          stall_if,
    output logic          ifid_wren,
    output logic          ifid_flush,
    output logic          idex_flush,
    output fwd_sel_t      rs1_sel,
    output fwd_sel_t      rs2_sel,
    output logic          wm_fwd_sel
);

    // Tracked stage state
    logic     e_valid;
    reg_idx_t e_rs1;
    reg_idx_t e_rs2;
    reg_idx_t e_rd;
    logic     e_regwren;
    logic     e_memren;
    opcode_t  e_opcode;
    logic     m_valid;
    reg_idx_t m_rd;
    reg_idx_t m_rs2;
    logic     m_regwren;
    logic     m_memwren;
    logic     w_valid;
    reg_idx_t w_rd;
    logic     w_regwren;

    // Configuration levels
    logic fwd_en;
    logic rf_bypass;

    hazard_cfg_regs u_cfg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .fwd_en    (fwd_en),
        .rf_bypass (rf_bypass)
    );

    stage_tracker u_tracker (
        .clk        (clk),
        .arst_n     (arst_n),
        .idex_flush (idex_flush),
        .d_valid    (d_valid),
        .d_rs1      (d_rs1),
        .d_rs2      (d_rs2),
        .d_rd       (d_rd),
        .d_regwren  (d_regwren),
        .d_memren   (d_memren),
        .d_memwren  (d_memwren),
        .d_opcode   (d_opcode),
        .e_valid    (e_valid),
        .e_rs1      (e_rs1),
        .e_rs2      (e_rs2),
        .e_rd       (e_rd),
        .e_regwren  (e_regwren),
        .e_memren   (e_memren),
        .e_opcode   (e_opcode),
        .m_valid    (m_valid),
        .m_rd       (m_rd),
        .m_rs2      (m_rs2),
        .m_regwren  (m_regwren),
        .m_memwren  (m_memwren),
        .w_valid    (w_valid),
        .w_rd       (w_rd),
        .w_regwren  (w_regwren)
    );

    hazard_detect u_hazard (
        .d_rs1      (d_rs1),
        .d_rs2      (d_rs2),
        .e_valid    (e_valid),
        .e_rd       (e_rd),
        .e_regwren  (e_regwren),
        .e_memren   (e_memren),
        .e_opcode   (e_opcode),
        .m_rd       (m_rd),
        .m_regwren  (m_regwren),
        .w_rd       (w_rd),
        .w_regwren  (w_regwren),
        .e_br_taken (e_br_taken),
        .fwd_en     (fwd_en),
        .rf_bypass  (rf_bypass),
        .stall_if   (stall_if),
        .ifid_wren  (ifid_wren),
        .ifid_flush (ifid_flush),
        .idex_flush (idex_flush)
    );

    forward_select u_fwd (
        .e_valid    (e_valid),
        .e_rs1      (e_rs1),
        .e_rs2      (e_rs2),
        .m_rd       (m_rd),
        .m_rs2      (m_rs2),
        .m_regwren  (m_regwren),
        .m_memwren  (m_memwren),
        .w_rd       (w_rd),
        .w_regwren  (w_regwren),
        .fwd_en     (fwd_en),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .wm_fwd_sel (wm_fwd_sel)
    );

endmodule

`default_nettype wire

/* tb_pipe_ctrl.sv */
//------------------------------
// Directed testbench for the pipeline control top level
// A stage model predicts every output on every cycle
// Tests keep ID fields steady on their own while a stall is expected
//------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
;

    localparam int      CLK_PERIOD      = 100;
    localparam int      WATCHDOG_CYCLES = 2000;
    localparam opcode_t OPC_OP          = 7'b0110011;
    localparam opcode_t OPC_BRANCH      = 7'b1100011;

    logic     clk;
    logic     arst_n;
    logic     d_valid;
    reg_idx_t d_rs1;
    reg_idx_t d_rs2;
    reg_idx_t d_rd;
    logic     d_regwren;
    logic     d_memren;
    logic     d_memwren;
    opcode_t  d_opcode;
    logic     e_br_taken;
    logic     cfg_we;
    hz_cfg_t  cfg_wdata;
    hz_cfg_t  cfg_rdata;
    logic     stall_if;
    logic     ifid_wren;
    logic     ifid_flush;
    logic     idex_flush;
    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    logic     wm_fwd_sel;

    // Values staged by the tests and applied on the next rising edge
    logic     s_valid;
    reg_idx_t s_rs1;
    reg_idx_t s_rs2;
    reg_idx_t s_rd;
    logic     s_regwren;
    logic     s_memren;
    logic     s_memwren;
    opcode_t  s_opcode;
    logic     s_br;
    logic     s_cfg_we;
    hz_cfg_t  s_cfg_wdata;

    // Stage model, EX then MEM then WB
    logic     x_valid;
    reg_idx_t x_rs2;
    reg_idx_t x_rd;
    logic     x_wr;
    logic     x_ld;
    logic     x_st;
    opcode_t  x_opc;
    reg_idx_t x_rs1;
    reg_idx_t mm_rd;
    reg_idx_t mm_rs2;
    logic     mm_wr;
    logic     mm_st;
    reg_idx_t wb_rd;
    logic     wb_wr;
    hz_cfg_t  cfg_model;

    // Expected outputs for the current cycle
    logic     exp_stall;
    logic     exp_cf;
    logic     exp_idex;
    fwd_sel_t exp_rs1;
    fwd_sel_t exp_rs2;
    logic     exp_wm;

    string    test_name;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rc;

    pipe_ctrl_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .d_valid    (d_valid),
        .d_rs1      (d_rs1),
        .d_rs2      (d_rs2),
        .d_rd       (d_rd),
        .d_regwren  (d_regwren),
        .d_memren   (d_memren),
        .d_memwren  (d_memwren),
        .d_opcode   (d_opcode),
        .e_br_taken (e_br_taken),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .stall_if   (stall_if),
        .ifid_wren  (ifid_wren),
        .ifid_flush (ifid_flush),
        .idex_flush (idex_flush),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .wm_fwd_sel (wm_fwd_sel)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //------------------------------
    // Compare tasks
    //------------------------------
    task automatic check_bit(input string label, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH test=%s signal=%s expected=%b actual=%b",
                     test_name, label, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_sel(input string label, input fwd_sel_t exp, input fwd_sel_t act);
        if (act !== exp) begin
            $display("MISMATCH test=%s signal=%s expected=%0d actual=%0d",
                     test_name, label, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_cfg(input string label, input hz_cfg_t exp, input hz_cfg_t act);
        if (act !== exp) begin
            $display("MISMATCH test=%s signal=%s expected=%b actual=%b",
                     test_name, label, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    //------------------------------
    // Stage model
    //------------------------------
    // True when a register is nonzero and read by the ID instruction
    function automatic logic hits_id(input reg_idx_t r);
        return (r != '0) && ((r == d_rs1) || (r == d_rs2));
    endfunction

    // MEM is the younger producer so it is looked at first
    function automatic fwd_sel_t pick_src(input reg_idx_t src);
        if (!cfg_model[0] || !x_valid) begin
            return FWD_NONE;
        end
        if (mm_wr && (mm_rd == src)) begin
            return FWD_MEM;
        end
        if (wb_wr && (wb_rd == src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    task automatic predict();
        logic ld_use;
        logic wb_hz;
        logic nf_hz;
        ld_use    = x_valid && x_ld && hits_id(x_rd);
        wb_hz     = wb_wr && hits_id(wb_rd) && !cfg_model[1];
        nf_hz     = !cfg_model[0] && ((x_wr && hits_id(x_rd)) || (mm_wr && hits_id(mm_rd)));
        exp_cf    = e_br_taken || (x_valid && ((x_opc == OPC_JAL) || (x_opc == OPC_JALR)));
        exp_stall = (ld_use || wb_hz || nf_hz) && !exp_cf;
        exp_idex  = exp_stall || exp_cf;
        exp_rs1   = pick_src(x_rs1);
        exp_rs2   = pick_src(x_rs2);
        exp_wm    = cfg_model[0] && mm_st && wb_wr && (wb_rd == mm_rs2);
    endtask

    // Called at the rising edge before the new inputs land
    task automatic advance_model();
        wb_wr  = mm_wr;
        wb_rd  = mm_rd;
        mm_wr  = x_wr;
        mm_rd  = x_rd;
        mm_rs2 = x_rs2;
        mm_st  = x_st;
        if (exp_idex) begin
            x_valid = 1'b0;
            x_wr    = 1'b0;
            x_ld    = 1'b0;
            x_st    = 1'b0;
        end else begin
            x_valid = d_valid;
            x_wr    = d_valid && d_regwren && (d_rd != '0);
            x_ld    = d_valid && d_memren;
            x_st    = d_valid && d_memwren;
        end
        x_rs1 = d_rs1;
        x_rs2 = d_rs2;
        x_rd  = d_rd;
        x_opc = d_opcode;
        if (cfg_we) begin
            cfg_model = cfg_wdata;
        end
    endtask

    //------------------------------
    // Drivers
    //------------------------------
    // One clock cycle with a full output compare at the falling edge
    task automatic tick();
        @(posedge clk);
        advance_model();
        d_valid    <= s_valid;
        d_rs1      <= s_rs1;
        d_rs2      <= s_rs2;
        d_rd       <= s_rd;
        d_regwren  <= s_regwren;
        d_memren   <= s_memren;
        d_memwren  <= s_memwren;
        d_opcode   <= s_opcode;
        e_br_taken <= s_br;
        cfg_we     <= s_cfg_we;
        cfg_wdata  <= s_cfg_wdata;
        @(negedge clk);
        predict();
        check_bit("stall_if", exp_stall, stall_if);
        check_bit("ifid_wren", !exp_stall, ifid_wren);
        check_bit("ifid_flush", exp_cf, ifid_flush);
        check_bit("idex_flush", exp_idex, idex_flush);
        check_sel("rs1_sel", exp_rs1, rs1_sel);
        check_sel("rs2_sel", exp_rs2, rs2_sel);
        check_bit("wm_fwd_sel", exp_wm, wm_fwd_sel);
        check_cfg("cfg_rdata", cfg_model, cfg_rdata);
    endtask

    task automatic set_instr(input logic v, input reg_idx_t rs1, input reg_idx_t rs2,
                             input reg_idx_t rd, input logic wr, input logic ld,
                             input logic st, input opcode_t opc);
        s_valid   = v;
        s_rs1     = rs1;
        s_rs2     = rs2;
        s_rd      = rd;
        s_regwren = wr;
        s_memren  = ld;
        s_memwren = st;
        s_opcode  = opc;
    endtask

    task automatic set_idle();
        set_instr(1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, OPC_OP);
    endtask

    // Empties EX, MEM and WB
    task automatic drain();
        set_idle();
        repeat (3) tick();
    endtask

    task automatic write_cfg(input hz_cfg_t v);
        s_cfg_we    = 1'b1;
        s_cfg_wdata = v;
        tick();
        s_cfg_we    = 1'b0;
        tick();
    endtask

    // Three distinct nonzero registers
    task automatic pick_regs();
        ra = reg_idx_t'($urandom_range(31, 1));
        rb = ra;
        while (rb == ra) begin
            rb = reg_idx_t'($urandom_range(31, 1));
        end
        rc = ra;
        while ((rc == ra) || (rc == rb)) begin
            rc = reg_idx_t'($urandom_range(31, 1));
        end
    endtask

    //------------------------------
    // Tests
    //------------------------------
    task automatic test_reset_cfg();
        test_name = "reset_cfg";
        set_idle();
        tick();
        check_bit("stall_if", 1'b0, stall_if);
        check_bit("ifid_wren", 1'b1, ifid_wren);
        check_bit("idex_flush", 1'b0, idex_flush);
        check_sel("rs1_sel", FWD_NONE, rs1_sel);
        check_cfg("cfg_rdata", HZ_CFG_RESET, cfg_rdata);
        write_cfg(2'b10);
        check_cfg("cfg_rdata", 2'b10, cfg_rdata);
        write_cfg(HZ_CFG_RESET);
    endtask

    task automatic test_fwd_priority();
        test_name = "fwd_priority";
        pick_regs();
        // Two writers of ra back to back, then the consumer
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_idle();
        tick();
        check_sel("rs1_sel", FWD_MEM, rs1_sel);
        check_sel("rs2_sel", FWD_NONE, rs2_sel);
        drain();
        // Writer of rb two slots ahead of the consumer
        set_instr(1'b1, '0, '0, rb, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, '0, '0, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, '0, rb, ra, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_idle();
        tick();
        check_sel("rs2_sel", FWD_WB, rs2_sel);
        drain();
        // A write to x0 is never forwarded
        set_instr(1'b1, '0, '0, '0, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, '0, '0, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_idle();
        tick();
        check_sel("rs1_sel", FWD_NONE, rs1_sel);
        check_sel("rs2_sel", FWD_NONE, rs2_sel);
        drain();
    endtask

    task automatic test_load_use();
        test_name = "load_use";
        pick_regs();
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b1, 1'b0, OPC_LOAD);
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        check_bit("stall_if", 1'b1, stall_if);
        check_bit("ifid_wren", 1'b0, ifid_wren);
        check_bit("idex_flush", 1'b1, idex_flush);
        // Consumer held in ID while the load moves on to MEM
        tick();
        check_bit("stall_if", 1'b0, stall_if);
        set_idle();
        tick();
        check_sel("rs1_sel", FWD_WB, rs1_sel);
        drain();
    endtask

    // Writer of ra reaches WB just as the consumer sits in ID
    task automatic wb_sequence();
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, '0, '0, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
    endtask

    task automatic test_wb_decode();
        test_name = "wb_decode";
        pick_regs();
        wb_sequence();
        check_bit("stall_if", 1'b1, stall_if);
        tick();
        check_bit("stall_if", 1'b0, stall_if);
        drain();
        write_cfg(2'b11);
        wb_sequence();
        check_bit("stall_if", 1'b0, stall_if);
        drain();
        // Forwarding off with write-through on
        write_cfg(2'b10);
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        check_bit("stall_if", 1'b1, stall_if);
        tick();
        check_bit("stall_if", 1'b1, stall_if);
        tick();
        check_bit("stall_if", 1'b0, stall_if);
        drain();
        // Forwarding cut just as the consumer reaches EX behind its producer
        write_cfg(HZ_CFG_RESET);
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        s_cfg_we    = 1'b1;
        s_cfg_wdata = 2'b10;
        tick();
        s_cfg_we = 1'b0;
        set_idle();
        tick();
        check_sel("rs1_sel", FWD_NONE, rs1_sel);
        drain();
        write_cfg(HZ_CFG_RESET);
    endtask

    task automatic redirect_check(input opcode_t opc, input logic br);
        set_instr(1'b1, '0, '0, rc, !br, 1'b0, 1'b0, opc);
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        s_br = br;
        tick();
        check_bit("ifid_flush", 1'b1, ifid_flush);
        check_bit("idex_flush", 1'b1, idex_flush);
        s_br = 1'b0;
        set_idle();
        tick();
        check_bit("ifid_flush", 1'b0, ifid_flush);
        drain();
    endtask

    task automatic test_ctrl_flow();
        test_name = "ctrl_flow";
        pick_regs();
        redirect_check(OPC_JAL, 1'b0);
        redirect_check(OPC_JALR, 1'b0);
        redirect_check(OPC_BRANCH, 1'b1);
        // Load-use and a redirect in the same cycle
        set_instr(1'b1, '0, '0, ra, 1'b1, 1'b1, 1'b0, OPC_LOAD);
        tick();
        set_instr(1'b1, ra, rb, rc, 1'b1, 1'b0, 1'b0, OPC_OP);
        s_br = 1'b1;
        tick();
        check_bit("stall_if", 1'b0, stall_if);
        check_bit("ifid_flush", 1'b1, ifid_flush);
        s_br = 1'b0;
        drain();
    endtask

    // Writer W then a second instruction reading W's rd as rs2
    task automatic store_sequence(input reg_idx_t wrd, input logic st, input logic cut_fwd);
        set_instr(1'b1, '0, '0, wrd, 1'b1, 1'b0, 1'b0, OPC_OP);
        tick();
        set_instr(1'b1, rb, wrd, st ? reg_idx_t'('0) : rc, !st, 1'b0, st,
                  st ? OPC_STORE : OPC_OP);
        tick();
        set_idle();
        s_cfg_we    = cut_fwd;
        s_cfg_wdata = 2'b00;
        tick();
        s_cfg_we = 1'b0;
        tick();
    endtask

    task automatic test_store_fwd();
        test_name = "store_fwd";
        pick_regs();
        store_sequence(ra, 1'b1, 1'b0);
        check_bit("wm_fwd_sel", 1'b1, wm_fwd_sel);
        drain();
        store_sequence('0, 1'b1, 1'b0);
        check_bit("wm_fwd_sel", 1'b0, wm_fwd_sel);
        drain();
        store_sequence(ra, 1'b0, 1'b0);
        check_bit("wm_fwd_sel", 1'b0, wm_fwd_sel);
        drain();
        store_sequence(ra, 1'b1, 1'b1);
        check_bit("wm_fwd_sel", 1'b0, wm_fwd_sel);
        write_cfg(HZ_CFG_RESET);
        drain();
    endtask

    //------------------------------
    // Run control
    //------------------------------
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles and the run did not finish",
                 WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(90311));
        clk        = 1'b0;
        arst_n     = 1'b0;
        d_valid    = 1'b0;
        d_rs1      = '0;
        d_rs2      = '0;
        d_rd       = '0;
        d_regwren  = 1'b0;
        d_memren   = 1'b0;
        d_memwren  = 1'b0;
        d_opcode   = OPC_OP;
        e_br_taken = 1'b0;
        cfg_we     = 1'b0;
        cfg_wdata  = HZ_CFG_RESET;
        s_br       = 1'b0;
        s_cfg_we   = 1'b0;
        s_cfg_wdata = HZ_CFG_RESET;
        set_idle();
        // Model starts empty, like the DUT after reset
        x_valid   = 1'b0;
        x_wr      = 1'b0;
        x_ld      = 1'b0;
        x_st      = 1'b0;
        x_rs1     = '0;
        x_rs2     = '0;
        x_rd      = '0;
        x_opc     = OPC_OP;
        mm_wr     = 1'b0;
        mm_st     = 1'b0;
        mm_rd     = '0;
        mm_rs2    = '0;
        wb_wr     = 1'b0;
        wb_rd     = '0;
        cfg_model = HZ_CFG_RESET;
        exp_idex  = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_cfg();
        test_fwd_priority();
        test_load_use();
        test_wb_decode();
        test_ctrl_flow();
        test_store_fwd();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
pipe_ctrl_pkg.sv
hazard_cfg_regs.sv
stage_tracker.sv
hazard_detect.sv
forward_select.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the pipeline control testbench with Verilator.
# The run fails when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_pipe_ctrl -f build.f -o tb_pipe_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_pipe_ctrl > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation passed"
exit 0
